//--- rtl/mips_config.svh
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

`define MIPS_XLEN  32
`define MIPS_NREGS 32

// bit positions of the instruction fields
`define MIPS_OPCODE_LSB 26
`define MIPS_RS_LSB     21
`define MIPS_RT_LSB     16
`define MIPS_RD_LSB     11
`define MIPS_SHAMT_LSB  6
`define MIPS_FUNCT_LSB  0
`define MIPS_IMM_W      16

`define MIPS_OPCODE_R  6'b000000
`define MIPS_OP_ADDIU  6'b001001
`define MIPS_OP_SLTI   6'b001010
`define MIPS_OP_SLTIU  6'b001011
`define MIPS_OP_ANDI   6'b001100
`define MIPS_OP_ORI    6'b001101
`define MIPS_OP_XORI   6'b001110
`define MIPS_OP_LUI    6'b001111

`define MIPS_FN_SLL    6'b000000
`define MIPS_FN_SRL    6'b000010
`define MIPS_FN_SRA    6'b000011
`define MIPS_FN_ADDU   6'b100001
`define MIPS_FN_SUBU   6'b100011
`define MIPS_FN_AND    6'b100100
`define MIPS_FN_OR     6'b100101
`define MIPS_FN_XOR    6'b100110
`define MIPS_FN_NOR    6'b100111
`define MIPS_FN_SLT    6'b101010
`define MIPS_FN_SLTU   6'b101011

`endif

//--- rtl/mipsPkg.sv
`default_nettype none

`include "mips_config.svh"

package mipsPkg;

    typedef logic [`MIPS_XLEN-1:0]          word_t;
    typedef logic [$clog2(`MIPS_NREGS)-1:0] regAddr_t;
    typedef logic [31:0]                    instr_t;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluNor,
        aluSlt,
        aluSltu,
        aluSll,
        aluSrl,
        aluSra,
        aluLui
    } aluOp_t;

    // decode stage holds the raw instruction only
    typedef struct packed {
        instr_t instr;
    } idPayload_t;

    typedef struct packed {
        aluOp_t   aluOp;
        logic     useImm;   // operand 2 from immediate
        logic     useShamt; // operand 1 from shift amount
        word_t    opA;      // rs value, forwarded
        word_t    opB;      // rt value, forwarded
        word_t    imm;      // already extended
        logic [4:0] shamt;
        logic     regWrite;
        regAddr_t dest;
    } exPayload_t;

endpackage

`default_nettype wire

//--- rtl/stageReg.sv
`timescale 1ns/1ps
`default_nettype none

module stageReg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rstN,
    input  logic     inValid,
    input  payload_t inData,
    output logic     outValid,
    output payload_t outData
);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else begin
            outValid <= inValid;
        end
    end

    // payload follows the input every cycle, valid qualifies it
    always_ff @(posedge clk) begin
        outData <= inData;
    end

    // a valid stage must carry fully known data downstream
    assert property (@(posedge clk) disable iff (!rstN)
        outValid |-> !$isunknown(outData));

endmodule

`default_nettype wire

//--- rtl/regFile.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_config.svh"

module regFile
    import mipsPkg::*;
(
    input  logic     clk,
    input  logic     rstN,
    input  regAddr_t rdAddr1,
    input  regAddr_t rdAddr2,
    output word_t    rdData1,
    output word_t    rdData2,
    input  logic     wrEn,
    input  regAddr_t wrAddr,
    input  word_t    wrData
);

    word_t regs [`MIPS_NREGS];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `MIPS_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrAddr != '0) begin
            regs[wrAddr] <= wrData;
        end
    end

    // same-cycle write is not bypassed, decode forwarding covers it
    assign rdData1 = (rdAddr1 == '0) ? '0 : regs[rdAddr1];
    assign rdData2 = (rdAddr2 == '0) ? '0 : regs[rdAddr2];

    // decoder is expected to turn $0 writes into bubbles
    assert property (@(posedge clk) disable iff (!rstN)
        wrEn |-> wrAddr != '0);

endmodule

`default_nettype wire

//--- rtl/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu
    import mipsPkg::*;
(
    input  exPayload_t exData,
    output word_t      result
);

    word_t      op1;
    word_t      op2;
    logic [4:0] shAmt;

    assign op1   = exData.useShamt ? word_t'(exData.shamt) : exData.opA;
    assign op2   = exData.useImm ? exData.imm : exData.opB;
    assign shAmt = op1[4:0]; // shifts take the low five bits only

    always_comb begin
        case (exData.aluOp)
            aluAdd:  result = op1 + op2;
            aluSub:  result = op1 - op2;
            aluAnd:  result = op1 & op2;
            aluOr:   result = op1 | op2;
            aluXor:  result = op1 ^ op2;
            aluNor:  result = ~(op1 | op2);
            aluSlt:  result = word_t'($signed(op1) < $signed(op2));
            aluSltu: result = word_t'(op1 < op2);
            aluSll:  result = op2 << shAmt;          // shifted value is rt
            aluSrl:  result = op2 >> shAmt;
            aluSra:  result = word_t'($signed(op2) >>> shAmt);
            aluLui:  result = op2 << 16;
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/instrDecode.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_config.svh"

module instrDecode
    import mipsPkg::*;
(
    input  logic       idValid,
    input  instr_t     idInstr,
    input  word_t      rdData1,
    input  word_t      rdData2,
    input  logic       exValid,
    input  regAddr_t   exDest,
    input  word_t      exResult,
    output regAddr_t   rdAddr1,
    output regAddr_t   rdAddr2,
    output logic       exValidNext,
    output exPayload_t exNext
);

    logic [5:0]             opcode;
    logic [5:0]             funct;
    logic [`MIPS_IMM_W-1:0] imm16;
    regAddr_t               rd;
    aluOp_t                 aluOp;
    logic                   useImm;
    logic                   useShamt;
    logic                   signExt;
    logic                   supported;
    regAddr_t               dest;
    logic                   regWrite;

    assign opcode  = idInstr[`MIPS_OPCODE_LSB +: 6];
    assign funct   = idInstr[`MIPS_FUNCT_LSB +: 6];
    assign imm16   = idInstr[`MIPS_IMM_W-1:0];
    assign rd      = idInstr[`MIPS_RD_LSB +: 5];
    assign rdAddr1 = idInstr[`MIPS_RS_LSB +: 5];
    assign rdAddr2 = idInstr[`MIPS_RT_LSB +: 5];

    always_comb begin
        aluOp     = aluAdd;
        useImm    = 1'b0;
        useShamt  = 1'b0;
        signExt   = 1'b0;
        supported = 1'b1;
        if (opcode == `MIPS_OPCODE_R) begin
            case (funct)
                `MIPS_FN_ADDU: aluOp = aluAdd;
                `MIPS_FN_SUBU: aluOp = aluSub;
                `MIPS_FN_AND:  aluOp = aluAnd;
                `MIPS_FN_OR:   aluOp = aluOr;
                `MIPS_FN_XOR:  aluOp = aluXor;
                `MIPS_FN_NOR:  aluOp = aluNor;
                `MIPS_FN_SLT:  aluOp = aluSlt;
                `MIPS_FN_SLTU: aluOp = aluSltu;
                `MIPS_FN_SLL: begin
                    aluOp    = aluSll;
                    useShamt = 1'b1;
                end
                `MIPS_FN_SRL: begin
                    aluOp    = aluSrl;
                    useShamt = 1'b1;
                end
                `MIPS_FN_SRA: begin
                    aluOp    = aluSra;
                    useShamt = 1'b1;
                end
                default: supported = 1'b0;
            endcase
        end else begin
            useImm = 1'b1;
            case (opcode)
                `MIPS_OP_ADDIU: begin
                    aluOp   = aluAdd;
                    signExt = 1'b1;
                end
                `MIPS_OP_SLTI: begin
                    aluOp   = aluSlt;
                    signExt = 1'b1;
                end
                `MIPS_OP_SLTIU: begin
                    aluOp   = aluSltu;
                    signExt = 1'b1; // sign-extended, then compared unsigned
                end
                `MIPS_OP_ANDI: aluOp = aluAnd;
                `MIPS_OP_ORI:  aluOp = aluOr;
                `MIPS_OP_XORI: aluOp = aluXor;
                `MIPS_OP_LUI:  aluOp = aluLui;
                default:       supported = 1'b0;
            endcase
        end
    end

    assign dest        = (opcode == `MIPS_OPCODE_R) ? rd : rdAddr2; // rt for I-type
    assign regWrite    = supported && (dest != '0); // bubble otherwise
    assign exValidNext = idValid && regWrite;

    always_comb begin
        exNext          = '0;
        exNext.aluOp    = aluOp;
        exNext.useImm   = useImm;
        exNext.useShamt = useShamt;
        exNext.imm      = signExt ? word_t'($signed(imm16)) : word_t'(imm16);
        exNext.shamt    = idInstr[`MIPS_SHAMT_LSB +: 5];
        exNext.regWrite = regWrite;
        exNext.dest     = dest;
        // execute result is one instruction ahead of the regfile
        exNext.opA = (exValid && exDest == rdAddr1) ? exResult : rdData1;
        exNext.opB = (exValid && exDest == rdAddr2) ? exResult : rdData2;
    end

endmodule

`default_nettype wire

//--- rtl/mipsCore.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCore
    import mipsPkg::*;
(
    input  logic     clk,
    input  logic     rstN,
    input  logic     instrValid,
    input  instr_t   instr,
    output logic     wbValid,
    output regAddr_t wbAddr,
    output word_t    wbData
);

    idPayload_t idIn;
    idPayload_t idOut;
    logic       idValid;
    regAddr_t   rdAddr1;
    regAddr_t   rdAddr2;
    word_t      rdData1;
    word_t      rdData2;
    logic       exValidNext;
    exPayload_t exNext;
    logic       exValid;
    exPayload_t exOut;
    word_t      exResult;

    assign idIn = '{instr: instr};

    stageReg #(.payload_t(idPayload_t)) idReg (
        .clk      (clk       ),
        .rstN     (rstN      ),
        .inValid  (instrValid), // no strobe means a bubble
        .inData   (idIn      ),
        .outValid (idValid   ),
        .outData  (idOut     )
    );

    instrDecode u_instrDecode (
        .idValid     (idValid    ),
        .idInstr     (idOut.instr),
        .rdData1     (rdData1    ),
        .rdData2     (rdData2    ),
        .exValid     (wbValid    ),
        .exDest      (wbAddr     ),
        .exResult    (wbData     ),
        .rdAddr1     (rdAddr1    ),
        .rdAddr2     (rdAddr2    ),
        .exValidNext (exValidNext),
        .exNext      (exNext     )
    );

    regFile u_regFile (
        .clk     (clk    ),
        .rstN    (rstN   ),
        .rdAddr1 (rdAddr1),
        .rdAddr2 (rdAddr2),
        .rdData1 (rdData1),
        .rdData2 (rdData2),
        .wrEn    (wbValid),
        .wrAddr  (wbAddr ),
        .wrData  (wbData )
    );

    stageReg #(.payload_t(exPayload_t)) exReg (
        .clk      (clk        ),
        .rstN     (rstN       ),
        .inValid  (exValidNext),
        .inData   (exNext     ),
        .outValid (exValid    ),
        .outData  (exOut      )
    );

    alu u_alu (
        .exData (exOut   ),
        .result (exResult)
    );

    // write-back straight out of execute, no memory stage
    assign wbValid = exValid && exOut.regWrite;
    assign wbAddr  = exOut.dest;
    assign wbData  = exResult;

endmodule

`default_nettype wire

//--- sim/tbMipsCore.sv
`timescale 1ns/1ps
`default_nettype none

module tbMipsCore
    import mipsPkg::*;
();

    localparam string traceFile   = "sim/aluTrace.txt";
    localparam int    resetCycles = 4;
    localparam int    clkPeriod   = 8; // ns
    localparam int    latency     = 2; // issue to write-back, in edges

    logic     clk;
    logic     rstN;
    logic     instrValid;
    instr_t   instr;
    logic     wbValid;
    regAddr_t wbAddr;
    word_t    wbData;

    // one entry per trace line
    logic     stimValid [$];
    instr_t   stimInstr [$];
    logic     expValid  [$];
    regAddr_t expAddr   [$];
    word_t    expData   [$];

    int cycleCount = 0;
    int cycleLimit = 0;

    mipsCore u_mipsCore (
        .clk        (clk       ),
        .rstN       (rstN      ),
        .instrValid (instrValid),
        .instr      (instr     ),
        .wbValid    (wbValid   ),
        .wbAddr     (wbAddr    ),
        .wbData     (wbData    )
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("run did not finish within %0d cycles", cycleLimit);
            $display("TESTS FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic readTrace();
        int          fd;
        int          n;
        string       line;
        logic [31:0] v;
        logic [31:0] i;
        logic [31:0] ev;
        logic [31:0] ea;
        logic [31:0] ed;
        fd = $fopen(traceFile, "r");
        if (fd == 0) begin
            $display("could not open trace file %s", traceFile);
            $display("TESTS FAILED");
            $fatal(1, "missing trace");
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            // 8'h23 is '#', a comment line
            if (n > 0 && line.getc(0) != 8'h23) begin
                if ($sscanf(line, "%h %h %h %h %h", v, i, ev, ea, ed) == 5) begin
                    stimValid.push_back(v[0]);
                    stimInstr.push_back(i);
                    expValid.push_back(ev[0]);
                    expAddr.push_back(ea[4:0]);
                    expData.push_back(ed);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic checkValue(string name, word_t expected, word_t actual);
        if (actual !== expected) begin
            $display("ERROR %s expected %h actual %h", name, expected, actual);
            $display("TESTS FAILED");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    // address and data only matter when a write is expected
    task automatic checkWriteBack(int idx);
        string tag;
        tag = $sformatf("trace entry %0d", idx);
        checkValue({tag, " wbValid"}, 32'(expValid[idx]), 32'(wbValid));
        if (expValid[idx]) begin
            checkValue({tag, " wbAddr"}, 32'(expAddr[idx]), 32'(wbAddr));
            checkValue({tag, " wbData"}, expData[idx], wbData);
        end
    endtask

    initial begin
        int n;
        rstN       = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        readTrace();
        if (stimValid.size() == 0) begin
            $display("trace file %s holds no entries", traceFile);
            $display("TESTS FAILED");
            $fatal(1, "empty trace");
        end
        cycleLimit = stimValid.size() + resetCycles + 10;
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        for (n = 0; n < stimValid.size() + latency; n++) begin
            if (n >= latency) begin
                checkWriteBack(n - latency); // issued two edges back
            end else begin
                checkValue("empty pipeline wbValid", 32'd0, 32'(wbValid));
            end
            if (n < stimValid.size()) begin
                instrValid = stimValid[n];
                instr      = stimInstr[n];
            end else begin
                instrValid = 1'b0; // drain
                instr      = '0;
            end
            @(negedge clk);
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+rtl
rtl/mipsPkg.sv
rtl/stageReg.sv
rtl/regFile.sv
rtl/alu.sv
rtl/instrDecode.sv
rtl/mipsCore.sv
sim/tbMipsCore.sv

//--- Makefile
TOP := tbMipsCore

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build output"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "^TESTS PASSED$$"

clean:
	rm -rf obj_dir

//--- sim/aluTrace.txt
# instrValid instr expWbValid expWbAddr expWbData, all hex
# expected write-back belongs to the instruction on the same line
1 24011234 1 01 00001234
1 2402FFF0 1 02 FFFFFFF0
# R-type, dependents one and two apart
1 00221821 1 03 00001224
1 00612023 1 04 FFFFFFF0
1 00812824 1 05 00001230
1 00A23025 1 06 FFFFFFF0
1 00253826 1 07 00000004
1 00204027 1 08 FFFFEDCB
1 0041482A 1 09 00000001
1 0041502B 1 0a 00000000
# shifts
1 00015900 1 0b 00012340
1 00026202 1 0c 00FFFFFF
1 00026A03 1 0d FFFFFFFF
# strobe low, the word must be ignored
0 24011111 0 00 00000000
# I-type
1 284EFFF8 1 0e 00000001
1 2C2F8000 1 0f 00000001
1 3050FF0F 1 10 0000FF00
1 34318001 1 11 00009235
1 3A32FFFF 1 12 00006DCA
1 3C13ABCD 1 13 ABCD0000
1 0272A021 1 14 ABCD6DCA
# write to $0, then read it back
1 24200005 0 00 00000000
1 24160007 1 16 00000007
# lw and mult are not decoded
1 8C220000 0 00 00000000
1 00220018 0 00 00000000
1 0002A821 1 15 FFFFFFF0
